/* all.f */
conv_pkg.sv
sync_fifo.sv
conv_csr.sv
line_conv.sv
burst_master.sv
conv_burst_top.sv
tb_conv_burst.sv

/* burst_master.sv */
module burst_master import conv_pkg::*; #(
    parameter int KX = 3
) (
    input  logic      clock,
    input  logic      clock_sreset,
    input  logic      go,
    input  conv_cfg_t cfg,
    output logic      busy,
    output mem_req_t  req,
    input  logic      waitrequest,
    input  logic      readdatavalid,
    output logic      kernel_load,
    output logic      src_push,
    output logic      dst_push,
    output logic      start_line,
    input  logic      line_done,
    input  count_t    result_used,
    output logic      result_pop
);
    burst_state_t state;
    burst_phase_t phase;
    count_t       word_count;
    count_t       lines_left;
    addr_t        src_addr;
    addr_t        dst_addr;
    addr_t        line_bytes;
    logic         last_read;
    logic         last_write;

    always_comb begin
        line_bytes = addr_t'(cfg.line_words) * addr_t'(BYTES_PER_PIXEL);
        last_read = readdatavalid && (word_count == req.burstcount - 1'b1);
        result_pop = (state == WRITE_BACK) && req.write && !waitrequest;
        last_write = result_pop && (word_count == req.burstcount - 1'b1);
        // read data goes wherever the current burst belongs
        kernel_load = readdatavalid && (state == KERNEL_READ);
        src_push = readdatavalid && (state == SRC_READ);
        dst_push = readdatavalid && (state == DST_READ);
    end

    always_ff @(posedge clock) begin
        if (clock_sreset) begin
            state <= IDLE;
            phase <= REQUEST;
            req.read <= 1'b0;
            req.write <= 1'b0;
            busy <= 1'b0;
            start_line <= 1'b0;
            word_count <= '0;
            lines_left <= '0;
        end else begin
            start_line <= 1'b0;
            case (state)
                IDLE: begin
                    word_count <= '0;
                    if (go) begin
                        busy <= 1'b1;
                        src_addr <= cfg.src_base;
                        dst_addr <= cfg.dst_base;
                        lines_left <= cfg.line_count;
                        req.address <= cfg.kernel_base;
                        req.burstcount <= count_t'(KX);
                        req.read <= 1'b1;
                        phase <= REQUEST;
                        state <= KERNEL_READ;
                    end
                end
                KERNEL_READ, SRC_READ, DST_READ: begin
                    word_count <= word_count + count_t'(readdatavalid);
                    if (phase == REQUEST) begin
                        if (!waitrequest) begin
                            req.read <= 1'b0;    // command taken
                            phase <= RECEIVE;
                        end
                    end else if (last_read) begin
                        word_count <= '0;
                        phase <= REQUEST;
                        req.burstcount <= cfg.line_words;
                        if (state == KERNEL_READ) begin
                            req.address <= src_addr;
                            req.read <= 1'b1;
                            state <= SRC_READ;
                        end else if (state == SRC_READ) begin
                            req.address <= dst_addr;
                            req.read <= 1'b1;
                            state <= DST_READ;
                        end else begin
                            start_line <= 1'b1;
                            state <= CONVOLVE;
                        end
                    end
                end
                CONVOLVE: begin
                    if (line_done) begin
                        req.address <= dst_addr;
                        state <= WRITE_BACK;
                    end
                end
                WRITE_BACK: begin
                    if (!req.write) begin
                        // hold off until the whole line is buffered
                        req.write <= result_used == cfg.line_words;
                    end else if (result_pop) begin
                        word_count <= word_count + 1'b1;
                        if (last_write) begin
                            req.write <= 1'b0;
                            word_count <= '0;
                            src_addr <= src_addr + line_bytes;
                            dst_addr <= dst_addr + line_bytes;
                            lines_left <= lines_left - 1'b1;
                            if (lines_left == 9'd1) begin
                                busy <= 1'b0;
                                state <= IDLE;
                            end else begin
                                req.address <= src_addr + line_bytes;
                                req.read <= 1'b1;
                                phase <= REQUEST;
                                state <= SRC_READ;
                            end
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    assert property (@(posedge clock) disable iff (clock_sreset) !(req.read && req.write));

endmodule

/* conv_burst_top.sv */
module conv_burst_top import conv_pkg::*; #(
    parameter int KX         = 3,
    parameter int PAD        = 1,
    parameter int FIFO_DEPTH = 256
) (
    input  logic                       clock,
    input  logic                       clock_sreset,
    input  reg_index_t                 s_address,
    input  word_t                      s_writedata,
    output word_t                      s_readdata,
    input  logic                       s_read,
    input  logic                       s_write,
    output logic                       s_waitrequest,
    output addr_t                      m_address,
    output count_t                     m_burstcount,
    output logic                       m_read,
    output logic                       m_write,
    output pixel_t                     m_writedata,
    output logic [BYTES_PER_PIXEL-1:0] m_byteenable,
    input  pixel_t                     m_readdata,
    input  logic                       m_readdatavalid,
    input  logic                       m_waitrequest
);
    conv_cfg_t cfg;
    mem_req_t  req;
    logic      go, busy, start_line, line_done, kernel_load;
    logic      src_push, src_pop, dst_push, dst_pop, result_push, result_pop;
    pixel_t    src_pixel, dst_pixel, result;
    count_t    src_used, dst_used, result_used;

    assign m_address = req.address;
    assign m_burstcount = req.burstcount;
    assign m_read = req.read;
    assign m_write = req.write;
    assign m_byteenable = '1;

    conv_csr csr (
        .clock, .clock_sreset, .s_address, .s_writedata, .s_readdata,
        .s_read, .s_write, .s_waitrequest, .busy, .go, .cfg
    );

    burst_master #(.KX(KX)) master (
        .clock, .clock_sreset, .go, .cfg, .busy, .req,
        .waitrequest(m_waitrequest), .readdatavalid(m_readdatavalid),
        .kernel_load, .src_push, .dst_push, .start_line, .line_done,
        .result_used, .result_pop
    );

    line_conv #(.KX(KX), .PAD(PAD)) conv (
        .clock, .clock_sreset, .kernel_load, .kernel_data(m_readdata),
        .start_line, .line_words(cfg.line_words), .src_pixel, .src_used,
        .dst_pixel, .dst_used, .src_pop, .dst_pop, .result, .result_push, .line_done
    );

    sync_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) src_fifo (
        .clock, .clock_sreset, .data(m_readdata), .push(src_push), .pop(src_pop),
        .q(src_pixel), .used(src_used)
    );

    sync_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) dst_fifo (
        .clock, .clock_sreset, .data(m_readdata), .push(dst_push), .pop(dst_pop),
        .q(dst_pixel), .used(dst_used)
    );

    sync_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) res_fifo (
        .clock, .clock_sreset, .data(result), .push(result_push), .pop(result_pop),
        .q(m_writedata), .used(result_used)
    );

endmodule

/* conv_csr.sv */
module conv_csr import conv_pkg::*; (
    input  logic       clock,
    input  logic       clock_sreset,
    input  reg_index_t s_address,
    input  word_t      s_writedata,
    output word_t      s_readdata,
    input  logic       s_read,
    input  logic       s_write,
    output logic       s_waitrequest,
    input  logic       busy,
    output logic       go,
    output conv_cfg_t  cfg
);
    logic read_wait;    // second cycle of a read

    assign s_waitrequest = s_read && !read_wait;

    always_ff @(posedge clock) begin
        if (clock_sreset) begin
            read_wait <= 1'b0;
            go <= 1'b0;
            cfg <= '0;
        end else begin
            read_wait <= s_read && !read_wait;
            // a start while running is ignored
            go <= s_write && (s_address == REG_CONTROL) && s_writedata[0] && !busy && !go;
            if (s_write) begin
                case (s_address)
                    REG_LINE_WORDS:  cfg.line_words <= count_t'(s_writedata);
                    REG_LINE_COUNT:  cfg.line_count <= count_t'(s_writedata);
                    REG_SRC_BASE:    cfg.src_base <= s_writedata;
                    REG_DST_BASE:    cfg.dst_base <= s_writedata;
                    REG_KERNEL_BASE: cfg.kernel_base <= s_writedata;
                    default: ;
                endcase
            end
        end
    end

    // readback register, valid when waitrequest drops
    always_ff @(posedge clock) begin
        case (s_address)
            REG_CONTROL:     s_readdata <= word_t'(busy);
            REG_LINE_WORDS:  s_readdata <= word_t'(cfg.line_words);
            REG_LINE_COUNT:  s_readdata <= word_t'(cfg.line_count);
            REG_SRC_BASE:    s_readdata <= cfg.src_base;
            REG_DST_BASE:    s_readdata <= cfg.dst_base;
            REG_KERNEL_BASE: s_readdata <= cfg.kernel_base;
            default:         s_readdata <= '0;
        endcase
    end

    // the master must have gone idle before a new start reaches it
    assert property (@(posedge clock) disable iff (clock_sreset) go |-> !busy);

endmodule

/* conv_pkg.sv */
package conv_pkg;

    typedef logic signed [15:0] pixel_t;    // pixel, coefficient and memory word
    typedef logic [31:0]        addr_t;     // byte address
    typedef logic [8:0]         count_t;    // burst and fifo word count
    typedef logic [31:0]        word_t;     // register slave data
    typedef logic [2:0]         reg_index_t;

    localparam reg_index_t REG_CONTROL     = 3'd0;  // bit 0 starts, read gives busy
    localparam reg_index_t REG_LINE_WORDS  = 3'd1;
    localparam reg_index_t REG_LINE_COUNT  = 3'd2;
    localparam reg_index_t REG_SRC_BASE    = 3'd3;
    localparam reg_index_t REG_DST_BASE    = 3'd4;
    localparam reg_index_t REG_KERNEL_BASE = 3'd5;

    localparam int BYTES_PER_PIXEL = 2;

    typedef struct packed {
        addr_t  src_base;
        addr_t  dst_base;
        addr_t  kernel_base;
        count_t line_words;
        count_t line_count;
    } conv_cfg_t;

    typedef struct packed {
        addr_t  address;
        count_t burstcount;
        logic   read;
        logic   write;
    } mem_req_t;

    typedef enum logic [2:0] {IDLE, KERNEL_READ, SRC_READ, DST_READ, CONVOLVE, WRITE_BACK}
        burst_state_t;

    typedef enum logic {REQUEST, RECEIVE} burst_phase_t;

endpackage

/* line_conv.sv */
module line_conv import conv_pkg::*; #(
    parameter int KX  = 3,
    parameter int PAD = 1
) (
    input  logic   clock,
    input  logic   clock_sreset,
    input  logic   kernel_load,
    input  pixel_t kernel_data,
    input  logic   start_line,
    input  count_t line_words,
    input  pixel_t src_pixel,
    input  count_t src_used,
    input  pixel_t dst_pixel,
    input  count_t dst_used,
    output logic   src_pop,
    output logic   dst_pop,
    output pixel_t result,
    output logic   result_push,
    output logic   line_done
);
    pixel_t coef [KX];
    pixel_t win [KX];     // win[0] is the oldest padded pixel
    pixel_t acc;
    count_t feed_count;   // padded pixels shifted in so far
    count_t res_count;
    logic   active;
    logic   step;
    logic   is_pad;
    logic   emits;
    logic   win_emit;     // window holds a full set of taps

    always_comb begin
        is_pad = (feed_count < count_t'(PAD)) || (feed_count >= line_words + count_t'(PAD));
        emits = feed_count >= count_t'(KX - 1);
        step = active && (is_pad || ((src_used != '0) && (dst_used != '0)));
        src_pop = step && !is_pad;
        dst_pop = win_emit;
    end

    always_comb begin
        acc = dst_pixel;    // feature-map sum
        for (int k = 0; k < KX; k++) begin
            acc = acc + pixel_t'(coef[k] * win[k]);
        end
    end

    always_ff @(posedge clock) begin
        if (kernel_load) begin
            coef[KX-1] <= kernel_data;
            for (int k = 0; k < KX - 1; k++) begin
                coef[k] <= coef[k+1];
            end
        end
        if (step) begin
            win[KX-1] <= is_pad ? '0 : src_pixel;
            for (int k = 0; k < KX - 1; k++) begin
                win[k] <= win[k+1];
            end
        end
        if (win_emit) begin
            result <= acc;
        end
    end

    always_ff @(posedge clock) begin
        if (clock_sreset) begin
            active <= 1'b0;
            feed_count <= '0;
            res_count <= '0;
            win_emit <= 1'b0;
            result_push <= 1'b0;
            line_done <= 1'b0;
        end else begin
            win_emit <= step && emits;
            result_push <= win_emit;
            line_done <= win_emit && (res_count == line_words - 1'b1);
            if (win_emit) begin
                res_count <= res_count + 1'b1;
            end
            if (start_line) begin
                active <= 1'b1;
                feed_count <= '0;
                res_count <= '0;
            end else if (step) begin
                feed_count <= feed_count + 1'b1;
                if (feed_count == line_words + count_t'(2 * PAD - 1)) begin
                    active <= 1'b0;    // right padding shifted in
                end
            end
        end
    end

    // exactly line_words results between start_line and line_done
    assert property (@(posedge clock) disable iff (clock_sreset)
        result_push |-> (res_count <= line_words));
    assert property (@(posedge clock) disable iff (clock_sreset)
        $fell(active) |=> line_done);

endmodule

/* run.sh */
#!/usr/bin/env bash
# build and run the convolution engine testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 --top-module tb_conv_burst -f all.f

# tee keeps the log even when the simulation stops with an error
./obj_dir/Vtb_conv_burst 2>&1 | tee sim.log

if grep -q "Simulation failed" sim.log; then
    echo "run.sh: simulation reported a failure"
    exit 1
fi
grep -q "Simulation completed successfully" sim.log

/* sync_fifo.sv */
module sync_fifo import conv_pkg::*; #(
    parameter int FIFO_DEPTH = 256
) (
    input  logic   clock,
    input  logic   clock_sreset,
    input  pixel_t data,
    input  logic   push,
    input  logic   pop,
    output pixel_t q,
    output count_t used
);
    localparam int AW = $clog2(FIFO_DEPTH);
    localparam logic [AW-1:0] PTR_LAST = AW'(FIFO_DEPTH - 1);

    pixel_t        mem [FIFO_DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;

    assign q = mem[rd_ptr];    // show-ahead head word

    always_ff @(posedge clock) begin
        if (push) begin
            mem[wr_ptr] <= data;
        end
    end

    always_ff @(posedge clock) begin
        if (clock_sreset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            used <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
            end
            used <= used + count_t'(push) - count_t'(pop);
        end
    end

    // the producer and consumer must respect the fill level
    assert property (@(posedge clock) disable iff (clock_sreset)
        push |-> (used != count_t'(FIFO_DEPTH)));
    assert property (@(posedge clock) disable iff (clock_sreset)
        pop |-> (used != '0));

endmodule

/* tb_conv_burst.sv */
module tb_conv_burst import conv_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int KX         = 3;
    localparam int PAD        = 1;
    localparam int FIFO_DEPTH = 256;
    localparam int MEM_WORDS  = 1024;
    localparam int WORDS_A    = 8;
    localparam int LINES_A    = 3;
    localparam int WORDS_B    = 5;
    localparam int LINES_B    = 2;
    // kernel, source, destination and result words of both runs
    localparam int WORDS_MOVED = (KX + 3 * WORDS_A * LINES_A) + (KX + 3 * WORDS_B * LINES_B);
    localparam int TIMEOUT_CYCLES = 20 * WORDS_MOVED + 2000;

    logic                       clock = 1'b0;
    logic                       clock_sreset;
    reg_index_t                 s_address;
    word_t                      s_writedata;
    word_t                      s_readdata;
    logic                       s_read;
    logic                       s_write;
    logic                       s_waitrequest;
    addr_t                      m_address;
    count_t                     m_burstcount;
    logic                       m_read;
    logic                       m_write;
    pixel_t                     m_writedata;
    logic [BYTES_PER_PIXEL-1:0] m_byteenable;
    pixel_t                     m_readdata;
    logic                       m_readdatavalid;
    logic                       m_waitrequest;

    pixel_t      mem [MEM_WORDS];
    pixel_t      expected_mem [MEM_WORDS];
    int          read_queue[$];     // word index of each pending read beat
    int          ready_queue[$];    // cycle in which that beat returns
    int          cycle_count;
    int          read_cmds;
    int          write_words;
    count_t      cfg_words;
    count_t      cfg_lines;
    addr_t       cfg_kbase;
    addr_t       cfg_sbase;
    addr_t       cfg_dbase;
    logic [16:0] lfsr_state = 17'd98024;

    conv_burst_top #(.KX(KX), .PAD(PAD), .FIFO_DEPTH(FIFO_DEPTH)) dut0 (
        .clock, .clock_sreset, .s_address, .s_writedata, .s_readdata, .s_read, .s_write,
        .s_waitrequest, .m_address, .m_burstcount, .m_read, .m_write, .m_writedata,
        .m_byteenable, .m_readdata, .m_readdatavalid, .m_waitrequest
    );

    always #5 clock = ~clock;

    // x^17 + x^14 + 1
    function automatic logic next_random_bit();
        logic feedback;
        feedback = lfsr_state[16] ^ lfsr_state[13];
        lfsr_state = {lfsr_state[15:0], feedback};
        return feedback;
    endfunction

    function automatic pixel_t random_pixel();
        logic [15:0] bits;
        bits = '0;
        for (int i = 0; i < 16; i++) begin
            bits = {bits[14:0], next_random_bit()};
        end
        return pixel_t'(bits);
    endfunction

    task automatic stop_on_error();
        $display("Simulation failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic report_mismatch(string name, logic [31:0] got, logic [31:0] expected);
        $display("mismatch at %0t: %s is %0h, expected %0h", $time, name, got, expected);
        stop_on_error();
    endtask

    task automatic report_failure(string what);
        $display("at %0t: %s", $time, what);
        stop_on_error();
    endtask

    // transfers seen here complete at the next rising edge
    task automatic observe_bus();
        addr_t  exp_addr;
        count_t exp_count;
        int     line;
        int     index;
        if (m_write) begin
            assert (m_byteenable == 2'b11)
                else report_mismatch("m_byteenable", 32'(m_byteenable), 32'h3);
        end
        if (m_read && !m_waitrequest) begin
            if (read_cmds == 0) begin
                exp_addr = cfg_kbase;
                exp_count = count_t'(KX);
            end else begin
                line = (read_cmds - 1) / 2;
                exp_addr = addr_t'(line * int'(cfg_words) * BYTES_PER_PIXEL);
                exp_addr = exp_addr + (((read_cmds - 1) % 2 == 0) ? cfg_sbase : cfg_dbase);
                exp_count = cfg_words;
            end
            assert (m_address == exp_addr) else report_mismatch("m_address", m_address, exp_addr);
            assert (m_burstcount == exp_count)
                else report_mismatch("m_burstcount", 32'(m_burstcount), 32'(exp_count));
            for (int i = 0; i < int'(m_burstcount); i++) begin
                read_queue.push_back(int'(m_address >> 1) + i);
                ready_queue.push_back(cycle_count + 2 + i);
            end
            read_cmds++;
        end
        if (m_write && !m_waitrequest) begin
            line = write_words / int'(cfg_words);
            exp_addr = cfg_dbase + addr_t'(line * int'(cfg_words) * BYTES_PER_PIXEL);
            assert (m_address == exp_addr) else report_mismatch("m_address", m_address, exp_addr);
            assert (m_burstcount == cfg_words)
                else report_mismatch("m_burstcount", 32'(m_burstcount), 32'(cfg_words));
            index = int'(m_address >> 1) + (write_words % int'(cfg_words));
            assert (index < MEM_WORDS) else report_failure("write burst outside the memory");
            mem[index] = m_writedata;
            write_words++;
        end
    endtask

    task automatic reach_mid_cycle();
        @(negedge clock);
        observe_bus();
    endtask

    task automatic reach_drive_point();
        @(posedge clock);
        #1;
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            report_failure($sformatf("timeout, run not finished after %0d cycles", cycle_count));
        end
        m_waitrequest = next_random_bit();
        if (read_queue.size() > 0 && ready_queue[0] <= cycle_count) begin
            m_readdata = mem[read_queue.pop_front()];
            void'(ready_queue.pop_front());
            m_readdatavalid = 1'b1;
        end else begin
            m_readdatavalid = 1'b0;
        end
    endtask

    task automatic run_cycle();
        reach_mid_cycle();
        reach_drive_point();
    endtask

    task automatic write_register(input reg_index_t index, input word_t value);
        s_address = index;
        s_writedata = value;
        s_write = 1'b1;
        run_cycle();
        s_write = 1'b0;
    endtask

    task automatic read_register(input reg_index_t index, output word_t value);
        s_address = index;
        s_read = 1'b1;
        reach_mid_cycle();
        assert (s_waitrequest) else report_mismatch("s_waitrequest", 32'(s_waitrequest), 32'd1);
        reach_drive_point();
        reach_mid_cycle();
        assert (!s_waitrequest)
            else report_mismatch("s_waitrequest", 32'(s_waitrequest), 32'd0);
        value = s_readdata;
        reach_drive_point();
        s_read = 1'b0;
    endtask

    task automatic check_register(input reg_index_t index, input word_t expected, string name);
        word_t value;
        read_register(index, value);
        assert (value == expected) else report_mismatch(name, value, expected);
    endtask

    task automatic build_expected();
        pixel_t kern [KX];
        int     s_word;
        int     d_word;
        int     j;
        int     sum;
        s_word = int'(cfg_sbase >> 1);
        d_word = int'(cfg_dbase >> 1);
        for (int i = 0; i < MEM_WORDS; i++) begin
            expected_mem[i] = mem[i];
        end
        for (int k = 0; k < KX; k++) begin
            kern[k] = mem[int'(cfg_kbase >> 1) + k];    // first word is tap 0
        end
        for (int line = 0; line < int'(cfg_lines); line++) begin
            for (int x = 0; x < int'(cfg_words); x++) begin
                sum = int'(mem[d_word + x]);
                for (int k = 0; k < KX; k++) begin
                    j = x + k - PAD;
                    if (j >= 0 && j < int'(cfg_words)) begin
                        sum = sum + int'(kern[k]) * int'(mem[s_word + j]);
                    end
                end
                expected_mem[d_word + x] = pixel_t'(sum);    // 16-bit wrap
            end
            s_word = s_word + int'(cfg_words);
            d_word = d_word + int'(cfg_words);
        end
    endtask

    task automatic run_config(input int words, input int lines, input addr_t kernel_base,
                              input addr_t src_base, input addr_t dst_base);
        word_t status;
        cfg_words = count_t'(words);
        cfg_lines = count_t'(lines);
        cfg_kbase = kernel_base;
        cfg_sbase = src_base;
        cfg_dbase = dst_base;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = random_pixel();
        end
        build_expected();
        read_cmds = 0;
        write_words = 0;

        write_register(REG_LINE_WORDS, word_t'(words));
        write_register(REG_LINE_COUNT, word_t'(lines));
        write_register(REG_SRC_BASE, src_base);
        write_register(REG_DST_BASE, dst_base);
        write_register(REG_KERNEL_BASE, kernel_base);
        check_register(REG_LINE_WORDS, word_t'(words), "line_words");
        check_register(REG_LINE_COUNT, word_t'(lines), "line_count");
        check_register(REG_SRC_BASE, src_base, "src_base");
        check_register(REG_DST_BASE, dst_base, "dst_base");
        check_register(REG_KERNEL_BASE, kernel_base, "kernel_base");

        write_register(REG_CONTROL, 32'd1);
        run_cycle();    // busy rises the cycle after go
        read_register(REG_CONTROL, status);
        assert (status == 32'd1) else report_mismatch("busy", status, 32'd1);
        do begin
            read_register(REG_CONTROL, status);
        end while (status[0]);
        read_register(REG_CONTROL, status);
        assert (status == 32'd0) else report_mismatch("busy", status, 32'd0);

        assert (read_cmds == 1 + 2 * lines)
            else report_mismatch("read command count", 32'(read_cmds), 32'(1 + 2 * lines));
        assert (write_words == words * lines)
            else report_mismatch("write word count", 32'(write_words), 32'(words * lines));
        for (int i = 0; i < MEM_WORDS; i++) begin
            assert (mem[i] == expected_mem[i])
                else report_mismatch($sformatf("mem[%0d]", i), {16'h0000, mem[i]},
                                     {16'h0000, expected_mem[i]});
        end
    endtask

    initial begin
        clock_sreset = 1'b1;
        s_address = REG_CONTROL;
        s_writedata = '0;
        s_read = 1'b0;
        s_write = 1'b0;
        m_readdata = '0;
        m_readdatavalid = 1'b0;
        m_waitrequest = 1'b0;
        cycle_count = 0;
        read_cmds = 0;
        write_words = 0;
        cfg_words = '0;
        cfg_lines = '0;
        cfg_kbase = '0;
        cfg_sbase = '0;
        cfg_dbase = '0;
        repeat (3) begin
            run_cycle();
        end
        clock_sreset = 1'b0;
        reach_mid_cycle();
        assert (!m_read && !m_write && !s_waitrequest)
            else report_failure("bus requests active after reset");
        reach_drive_point();

        run_config(WORDS_A, LINES_A, 32'h020, 32'h100, 32'h300);
        run_config(WORDS_B, LINES_B, 32'h060, 32'h180, 32'h340);

        $display("Simulation completed successfully");
        $finish;
    end

endmodule
